/* verilog/share_mem_pkg.sv */
`default_nettype none

package share_mem_pkg;

    localparam int word_bits = 32;  // data and address width
    localparam int tag_bits  = 7;
    localparam int cmd_bits  = 5;
    localparam int typ_bits  = 3;

    // memory commands
    localparam logic [cmd_bits-1:0] cmd_load  = 5'd0;
    localparam logic [cmd_bits-1:0] cmd_store = 5'd1;

    // access size codes
    localparam logic [typ_bits-1:0] typ_b  = 3'd0;  // signed byte
    localparam logic [typ_bits-1:0] typ_h  = 3'd1;  // signed half
    localparam logic [typ_bits-1:0] typ_w  = 3'd2;
    localparam logic [typ_bits-1:0] typ_bu = 3'd4;  // unsigned byte
    localparam logic [typ_bits-1:0] typ_hu = 3'd5;  // unsigned half

    // byte address, flat or split into word index and byte offset
    typedef union packed {
        logic [word_bits-1:0] flat;
        struct packed {
            logic [word_bits-3:0] index;
            logic [1:0]           offset;
        } word;
    } byte_addr_t;

endpackage

`default_nettype wire

/* verilog/byte_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_memory #(
    parameter int mem_depth = 256  // bytes, power of two
) (
    input  logic                                clock,
    input  logic                                preload_en,
    input  logic [share_mem_pkg::word_bits-1:0] preload_addr,
    input  logic [7:0]                          preload_byte,
    input  share_mem_pkg::byte_addr_t           fetch_addr,
    input  share_mem_pkg::byte_addr_t           load_addr,
    input  share_mem_pkg::byte_addr_t           merge_addr,
    input  share_mem_pkg::byte_addr_t           gm_addr,
    output logic [share_mem_pkg::word_bits-1:0] fetch_word,
    output logic [share_mem_pkg::word_bits-1:0] load_word,
    output logic [share_mem_pkg::word_bits-1:0] merge_word,
    output logic [share_mem_pkg::word_bits-1:0] gm_word
);
    localparam int aw = $clog2(mem_depth);  // addresses wrap at mem_depth

    logic [7:0] mem [mem_depth];
    logic [share_mem_pkg::word_bits-1:0] rd_addr [4];
    wire  [share_mem_pkg::word_bits-1:0] rd_word [4];

    always_ff @(posedge clock) begin
        if (preload_en) mem[preload_addr[aw-1:0]] <= preload_byte;  // no read-back path
    end

    // port order: fetch, load, merge, golden
    assign rd_addr[0] = fetch_addr.flat;
    assign rd_addr[1] = load_addr.flat;
    assign rd_addr[2] = merge_addr.flat;
    assign rd_addr[3] = gm_addr.flat;

    for (genvar p = 0; p < 4; p++) begin : g_port
        for (genvar b = 0; b < 4; b++) begin : g_byte
            logic [share_mem_pkg::word_bits-1:0] byte_addr;
            assign byte_addr = rd_addr[p] + 32'(b);  // may roll past the top
            assign rd_word[p][8*b +: 8] = mem[byte_addr[aw-1:0]];  // little endian
        end
    end

    assign fetch_word = rd_word[0];
    assign load_word  = rd_word[1];
    assign merge_word = rd_word[2];
    assign gm_word    = rd_word[3];

endmodule

`default_nettype wire

/* verilog/imem_fetch_port.sv */
`timescale 1ns/100ps
`default_nettype none

module imem_fetch_port #(
    parameter logic [share_mem_pkg::word_bits-1:0] reset_pc = 32'd4096
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                imem_req_valid,
    input  logic [share_mem_pkg::word_bits-1:0] imem_req_pc,
    input  logic                                imem_resp_valid,
    input  logic                                imem_resp_ready,
    input  logic [share_mem_pkg::word_bits-1:0] fetch_word,
    output share_mem_pkg::byte_addr_t           fetch_addr,
    output logic [share_mem_pkg::word_bits-1:0] imem_resp_pc,
    output logic [share_mem_pkg::word_bits-1:0] imem_resp_data
);
    logic [share_mem_pkg::word_bits-1:0] pc_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= reset_pc;
        end else if (imem_req_valid) begin  // request always accepted
            pc_q <= imem_req_pc;
        end else if (imem_resp_valid && imem_resp_ready) begin
            pc_q <= pc_q + 32'd4;  // next sequential instruction
        end
    end

    assign fetch_addr.flat = pc_q;
    assign imem_resp_pc    = pc_q;        // echoed with the data
    assign imem_resp_data  = fetch_word;  // word at pc, zero latency

endmodule

`default_nettype wire

/* verilog/dmem_req_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_req_pipeline (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dmem_req_valid,
    input  logic                                dmem_req_ready,
    input  logic [share_mem_pkg::word_bits-1:0] dmem_req_addr,
    input  logic [share_mem_pkg::tag_bits-1:0]  dmem_req_tag,
    input  logic [share_mem_pkg::cmd_bits-1:0]  dmem_req_cmd,
    input  logic [share_mem_pkg::typ_bits-1:0]  dmem_req_typ,
    input  logic                                dmem_kill,
    input  logic [share_mem_pkg::word_bits-1:0] dmem_s1_data,
    input  logic                                resp_grant,
    output logic                                dmem_s2_nack,
    output logic                                dmem_replay_next,
    output logic                                dmem_ordered,
    output logic                                dmem_resp_valid,
    output logic                                dmem_resp_replay,
    output logic                                pending_valid,
    output share_mem_pkg::byte_addr_t           held_addr,
    output logic [share_mem_pkg::tag_bits-1:0]  held_tag,
    output logic [share_mem_pkg::cmd_bits-1:0]  held_cmd,
    output logic [share_mem_pkg::typ_bits-1:0]  held_typ,
    output logic [share_mem_pkg::word_bits-1:0] held_data
);
    logic stage1_valid;
    logic stage2_valid;
    logic ordered_d1;
    logic ordered_d2;
    logic s1_next;    // next-state valids
    logic s2_next;
    logic pend_next;
    logic s2_accept;  // stage 2 survives into pending

    logic [share_mem_pkg::word_bits-1:0] s1_addr;
    logic [share_mem_pkg::tag_bits-1:0]  s1_tag;
    logic [share_mem_pkg::cmd_bits-1:0]  s1_cmd;
    logic [share_mem_pkg::typ_bits-1:0]  s1_typ;
    logic [share_mem_pkg::word_bits-1:0] s2_addr;
    logic [share_mem_pkg::tag_bits-1:0]  s2_tag;
    logic [share_mem_pkg::cmd_bits-1:0]  s2_cmd;
    logic [share_mem_pkg::typ_bits-1:0]  s2_typ;
    logic [share_mem_pkg::word_bits-1:0] s2_data;

    assign s1_next   = dmem_req_valid & dmem_req_ready;
    assign s2_next   = stage1_valid & ~dmem_kill;  // kill seen in stage 1 only
    assign s2_accept = stage2_valid & ~dmem_s2_nack;
    // new request wins over the response clearing the slot
    assign pend_next = s2_accept | (pending_valid & ~dmem_resp_valid);

    // slot busy, or ordering lost two cycles back
    assign dmem_s2_nack = stage2_valid & ((pending_valid & ~dmem_resp_valid) | ~ordered_d2);
    assign dmem_replay_next = pending_valid & ~dmem_resp_valid & resp_grant;
    // low when two in-flight slots would fill at once
    assign dmem_ordered = ~((s1_next & s2_next) | (s2_next & pend_next) |
                            (s1_next & pend_next));
    assign dmem_resp_replay = dmem_resp_valid;  // every response is a replay

    always_ff @(posedge clock) begin
        if (reset) begin
            stage1_valid    <= 1'b0;
            stage2_valid    <= 1'b0;
            pending_valid   <= 1'b0;
            dmem_resp_valid <= 1'b0;
            ordered_d1      <= 1'b0;
            ordered_d2      <= 1'b0;
        end else begin
            stage1_valid    <= s1_next;
            stage2_valid    <= s2_next;
            pending_valid   <= pend_next;
            dmem_resp_valid <= dmem_replay_next;  // one cycle behind replay
            ordered_d1      <= dmem_ordered;
            ordered_d2      <= ordered_d1;
        end
    end

    // request fields follow the valids
    always_ff @(posedge clock) begin
        s1_addr <= dmem_req_addr;
        s1_tag  <= dmem_req_tag;
        s1_cmd  <= dmem_req_cmd;
        s1_typ  <= dmem_req_typ;
        s2_addr <= s1_addr;
        s2_tag  <= s1_tag;
        s2_cmd  <= s1_cmd;
        s2_typ  <= s1_typ;
        s2_data <= dmem_s1_data;  // store data arrives a cycle late
        if (s2_accept) begin
            held_addr.flat <= s2_addr;
            held_tag       <= s2_tag;
            held_cmd       <= s2_cmd;
            held_typ       <= s2_typ;
            held_data      <= s2_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/dmem_data_align.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_data_align (
    input  share_mem_pkg::byte_addr_t           held_addr,
    input  logic [share_mem_pkg::cmd_bits-1:0]  held_cmd,
    input  logic [share_mem_pkg::typ_bits-1:0]  held_typ,
    input  logic [share_mem_pkg::word_bits-1:0] held_data,
    input  logic [share_mem_pkg::word_bits-1:0] load_word,
    input  logic [share_mem_pkg::word_bits-1:0] merge_word,
    output share_mem_pkg::byte_addr_t           load_addr,
    output share_mem_pkg::byte_addr_t           merge_addr,
    output logic [share_mem_pkg::word_bits-1:0] dmem_resp_data,
    output logic                                dmem_resp_has_data,
    output logic [share_mem_pkg::word_bits-1:0] store_word
);
    logic [4:0]                          shift;     // byte offset in bits
    logic [share_mem_pkg::word_bits-1:0] load_ext;
    logic [share_mem_pkg::word_bits-1:0] mask;
    logic [share_mem_pkg::word_bits-1:0] wdata;

    assign load_addr = held_addr;  // unaligned read from the exact byte

    always_comb begin
        case (held_typ)
            share_mem_pkg::typ_b:  load_ext = {{24{load_word[7]}}, load_word[7:0]};
            share_mem_pkg::typ_h:  load_ext = {{16{load_word[15]}}, load_word[15:0]};
            share_mem_pkg::typ_bu: load_ext = {24'd0, load_word[7:0]};
            share_mem_pkg::typ_hu: load_ext = {16'd0, load_word[15:0]};
            default:               load_ext = load_word;  // word
        endcase
    end

    assign dmem_resp_has_data = (held_cmd == share_mem_pkg::cmd_load);
    assign dmem_resp_data     = dmem_resp_has_data ? load_ext : '0;

    // store merges into the aligned word
    assign merge_addr.word.index  = held_addr.word.index;
    assign merge_addr.word.offset = 2'b00;
    assign shift = {held_addr.word.offset, 3'b000};

    always_comb begin
        case (held_typ)
            share_mem_pkg::typ_b, share_mem_pkg::typ_bu: begin
                mask  = 32'h0000_00ff << shift;
                wdata = held_data << shift;  // low byte lands in its lane
            end
            share_mem_pkg::typ_h, share_mem_pkg::typ_hu: begin
                mask  = 32'h0000_ffff << shift;
                wdata = held_data << shift;
            end
            default: begin
                mask  = '1;  // whole word, no shift
                wdata = held_data;
            end
        endcase
    end

    assign store_word = (merge_word & ~mask) | (wdata & mask);

endmodule

`default_nettype wire

/* verilog/write_compare.sv */
`timescale 1ns/100ps
`default_nettype none

module write_compare (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                pending_valid,
    input  logic [share_mem_pkg::cmd_bits-1:0]  held_cmd,
    input  share_mem_pkg::byte_addr_t           held_addr,
    input  logic [share_mem_pkg::word_bits-1:0] store_word,
    input  logic                                gm_wen,
    input  logic [share_mem_pkg::word_bits-1:0] gm_waddr,   // word index
    input  logic [share_mem_pkg::word_bits-1:0] gm_wdata,
    output logic                                mem_mismatch
);
    logic                                core_dirty;
    logic [share_mem_pkg::word_bits-3:0] core_index;
    logic [share_mem_pkg::word_bits-1:0] core_data;
    logic                                gm_dirty;
    logic [share_mem_pkg::word_bits-3:0] gm_index;
    logic [share_mem_pkg::word_bits-1:0] gm_data;
    logic                                core_write;

    assign core_write = pending_valid && (held_cmd == share_mem_pkg::cmd_store);

    always_ff @(posedge clock) begin
        if (reset) begin
            core_dirty <= 1'b0;
            gm_dirty   <= 1'b0;
        end else begin
            if (core_write) core_dirty <= 1'b1;  // sticky until reset
            if (gm_wen)     gm_dirty   <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (core_write) begin
            core_index <= held_addr.word.index;
            core_data  <= store_word;  // already merged with old bytes
        end
        if (gm_wen) begin
            gm_index <= gm_waddr[share_mem_pkg::word_bits-3:0];
            gm_data  <= gm_wdata;
        end
    end

    // one side wrote and the other did not, or both wrote different things
    assign mem_mismatch = (core_dirty != gm_dirty) ? 1'b1 :
                          (!core_dirty) ? 1'b0 :
                          ((core_index != gm_index) || (core_data != gm_data));

endmodule

`default_nettype wire

/* verilog/share_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module share_mem_top #(
    parameter logic [share_mem_pkg::word_bits-1:0] reset_pc  = 32'd4096,
    parameter int                                  mem_depth = 256
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                preload_en,
    input  logic [share_mem_pkg::word_bits-1:0] preload_addr,
    input  logic [7:0]                          preload_byte,
    input  logic                                imem_req_valid,
    input  logic [share_mem_pkg::word_bits-1:0] imem_req_pc,
    input  logic                                imem_resp_valid,
    input  logic                                imem_resp_ready,
    output logic [share_mem_pkg::word_bits-1:0] imem_resp_pc,
    output logic [share_mem_pkg::word_bits-1:0] imem_resp_data,
    input  logic                                dmem_req_valid,
    input  logic                                dmem_req_ready,
    input  logic [share_mem_pkg::word_bits-1:0] dmem_req_addr,
    input  logic [share_mem_pkg::tag_bits-1:0]  dmem_req_tag,
    input  logic [share_mem_pkg::cmd_bits-1:0]  dmem_req_cmd,
    input  logic [share_mem_pkg::typ_bits-1:0]  dmem_req_typ,
    input  logic                                dmem_kill,
    input  logic [share_mem_pkg::word_bits-1:0] dmem_s1_data,
    input  logic                                resp_grant,
    output logic                                dmem_s2_nack,
    output logic                                dmem_replay_next,
    output logic                                dmem_ordered,
    output logic                                dmem_resp_valid,
    output logic                                dmem_resp_replay,
    output logic [share_mem_pkg::word_bits-1:0] dmem_resp_addr,
    output logic [share_mem_pkg::tag_bits-1:0]  dmem_resp_tag,
    output logic [share_mem_pkg::cmd_bits-1:0]  dmem_resp_cmd,
    output logic [share_mem_pkg::typ_bits-1:0]  dmem_resp_typ,
    output logic [share_mem_pkg::word_bits-1:0] dmem_resp_data,
    output logic                                dmem_resp_has_data,
    input  logic [share_mem_pkg::word_bits-1:0] gm_raddr,  // word index
    output logic [share_mem_pkg::word_bits-1:0] gm_rdata,
    input  logic                                gm_wen,
    input  logic [share_mem_pkg::word_bits-1:0] gm_waddr,
    input  logic [share_mem_pkg::word_bits-1:0] gm_wdata,
    output logic                                mem_mismatch
);
    share_mem_pkg::byte_addr_t fetch_addr;
    share_mem_pkg::byte_addr_t load_addr;
    share_mem_pkg::byte_addr_t merge_addr;
    share_mem_pkg::byte_addr_t gm_addr;
    share_mem_pkg::byte_addr_t held_addr;
    logic [share_mem_pkg::word_bits-1:0] fetch_word;
    logic [share_mem_pkg::word_bits-1:0] load_word;
    logic [share_mem_pkg::word_bits-1:0] merge_word;
    logic [share_mem_pkg::word_bits-1:0] held_data;
    logic [share_mem_pkg::word_bits-1:0] store_word;
    logic                                pending_valid;

    assign gm_addr.word.index  = gm_raddr[share_mem_pkg::word_bits-3:0];
    assign gm_addr.word.offset = 2'b00;
    assign dmem_resp_addr      = held_addr.flat;

    byte_memory #(.mem_depth(mem_depth)) u_mem (
        .clock(clock), .preload_en(preload_en), .preload_addr(preload_addr),
        .preload_byte(preload_byte), .fetch_addr(fetch_addr), .load_addr(load_addr),
        .merge_addr(merge_addr), .gm_addr(gm_addr), .fetch_word(fetch_word),
        .load_word(load_word), .merge_word(merge_word), .gm_word(gm_rdata)
    );

    imem_fetch_port #(.reset_pc(reset_pc)) u_fetch (
        .clock(clock), .reset(reset), .imem_req_valid(imem_req_valid),
        .imem_req_pc(imem_req_pc), .imem_resp_valid(imem_resp_valid),
        .imem_resp_ready(imem_resp_ready), .fetch_word(fetch_word),
        .fetch_addr(fetch_addr), .imem_resp_pc(imem_resp_pc), .imem_resp_data(imem_resp_data)
    );

    // held fields double as the response fields
    dmem_req_pipeline u_pipe (
        .clock(clock), .reset(reset), .dmem_req_valid(dmem_req_valid),
        .dmem_req_ready(dmem_req_ready), .dmem_req_addr(dmem_req_addr),
        .dmem_req_tag(dmem_req_tag), .dmem_req_cmd(dmem_req_cmd), .dmem_req_typ(dmem_req_typ),
        .dmem_kill(dmem_kill), .dmem_s1_data(dmem_s1_data), .resp_grant(resp_grant),
        .dmem_s2_nack(dmem_s2_nack), .dmem_replay_next(dmem_replay_next),
        .dmem_ordered(dmem_ordered), .dmem_resp_valid(dmem_resp_valid),
        .dmem_resp_replay(dmem_resp_replay), .pending_valid(pending_valid),
        .held_addr(held_addr), .held_tag(dmem_resp_tag), .held_cmd(dmem_resp_cmd),
        .held_typ(dmem_resp_typ), .held_data(held_data)
    );

    dmem_data_align u_align (
        .held_addr(held_addr), .held_cmd(dmem_resp_cmd), .held_typ(dmem_resp_typ),
        .held_data(held_data), .load_word(load_word), .merge_word(merge_word),
        .load_addr(load_addr), .merge_addr(merge_addr), .dmem_resp_data(dmem_resp_data),
        .dmem_resp_has_data(dmem_resp_has_data), .store_word(store_word)
    );

    write_compare u_cmp (
        .clock(clock), .reset(reset), .pending_valid(pending_valid),
        .held_cmd(dmem_resp_cmd), .held_addr(held_addr), .store_word(store_word),
        .gm_wen(gm_wen), .gm_waddr(gm_waddr), .gm_wdata(gm_wdata),
        .mem_mismatch(mem_mismatch)
    );

endmodule

`default_nettype wire

/* verif/tb_share_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_share_mem;
    localparam int         n_rows  = 18;
    localparam int         timeout = 20;  // cycles per wait
    localparam logic [1:0] k_req   = 2'd0;  // one request, golden write after a store
    localparam logic [1:0] k_pair  = 2'd1;  // two requests on back-to-back edges
    localparam logic [1:0] k_gmw   = 2'd2;  // golden write of the last prediction
    localparam logic [1:0] k_gmr   = 2'd3;  // golden read port
    localparam logic [2:0] sz_b    = share_mem_pkg::typ_b;
    localparam logic [2:0] sz_h    = share_mem_pkg::typ_h;
    localparam logic [2:0] sz_w    = share_mem_pkg::typ_w;
    localparam logic [2:0] sz_bu   = share_mem_pkg::typ_bu;
    localparam logic [2:0] sz_hu   = share_mem_pkg::typ_hu;
    localparam logic [4:0] c_ld    = share_mem_pkg::cmd_load;
    localparam logic [4:0] c_st    = share_mem_pkg::cmd_store;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [2:0]  typ;
        logic [4:0]  cmd;
        logic [6:0]  tag;
        logic [31:0] sdata;
        logic        kill;
        logic [31:0] gm_flip;  // xor into the predicted word
        logic        exp_mm;   // mem_mismatch after the row
    } row_t;

    logic        clock           = 1'b0;
    logic        reset           = 1'b1;
    logic        preload_en      = 1'b0;
    logic [31:0] preload_addr    = '0;
    logic [7:0]  preload_byte    = '0;
    logic        imem_req_valid  = 1'b0;
    logic [31:0] imem_req_pc     = '0;
    logic        imem_resp_valid = 1'b0;
    logic        imem_resp_ready = 1'b0;
    logic        dmem_req_valid  = 1'b0;
    logic        dmem_req_ready  = 1'b0;
    logic [31:0] dmem_req_addr   = '0;
    logic [6:0]  dmem_req_tag    = '0;
    logic [4:0]  dmem_req_cmd    = '0;
    logic [2:0]  dmem_req_typ    = '0;
    logic        dmem_kill       = 1'b0;
    logic [31:0] dmem_s1_data    = '0;
    logic        resp_grant      = 1'b0;
    logic [31:0] gm_raddr        = '0;  // word index
    logic        gm_wen          = 1'b0;
    logic [31:0] gm_waddr        = '0;
    logic [31:0] gm_wdata        = '0;
    logic [31:0] imem_resp_pc, imem_resp_data, dmem_resp_addr, dmem_resp_data, gm_rdata;
    logic        dmem_s2_nack, dmem_replay_next, dmem_ordered, dmem_resp_valid;
    logic        dmem_resp_replay, dmem_resp_has_data, mem_mismatch;
    logic [6:0]  dmem_resp_tag;
    logic [4:0]  dmem_resp_cmd;
    logic [2:0]  dmem_resp_typ;

    logic [7:0]  model [256];  // copy of the preloaded bytes
    logic [31:0] seed;
    logic [31:0] last_store;   // predicted merged word of the latest store
    row_t        ops [n_rows];
    int          errors      = 0;
    int          other_fails = 0;

    share_mem_top #(.reset_pc(32'd4096), .mem_depth(256)) UUT (.*);

    initial begin
        forever #4 clock = ~clock;  // 8 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [7:0] p;
        p = a[7:0];  // wraps like the 256-byte array
        return {model[p + 8'd3], model[p + 8'd2], model[p + 8'd1], model[p]};
    endfunction

    function automatic logic [31:0] load_expect(input logic [31:0] a, input logic [2:0] typ);
        logic [31:0] w;
        w = word_at(a);
        case (typ)
            sz_b:    return 32'($signed(w[7:0]));
            sz_h:    return 32'($signed(w[15:0]));
            sz_bu:   return 32'(w[7:0]);
            sz_hu:   return 32'(w[15:0]);
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] store_expect(input logic [31:0] a, input logic [2:0] typ,
                                                 input logic [31:0] d);
        logic [31:0] w;
        int          n;
        int          off;
        w   = word_at({a[31:2], 2'b00});  // old aligned word
        off = int'(a[1:0]);
        n   = 4;
        if (typ == sz_b || typ == sz_bu) n = 1;
        if (typ == sz_h || typ == sz_hu) n = 2;
        for (int k = 0; k < n; k++)
            w[8*(off+k) +: 8] = d[8*k +: 8];  // new bytes over old ones
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic gm_write(input logic [31:0] index, input logic [31:0] data);
        @(posedge clock);
        gm_wen   <= 1'b1;
        gm_waddr <= index;
        gm_wdata <= data;
        @(posedge clock);
        gm_wen <= 1'b0;
    endtask

    task automatic run_req(input row_t r);
        int   t;
        logic seen;
        @(posedge clock);
        dmem_req_valid <= 1'b1;
        dmem_req_addr  <= r.addr;
        dmem_req_tag   <= r.tag;
        dmem_req_cmd   <= r.cmd;
        dmem_req_typ   <= r.typ;
        @(posedge clock);  // accepted, stage 1 follows
        dmem_req_valid <= 1'b0;
        dmem_kill      <= r.kill;
        dmem_s1_data   <= r.sdata;
        @(posedge clock);
        dmem_kill <= 1'b0;
        seen = 1'b0;
        for (t = 0; t < timeout && !seen; t++) begin
            @(negedge clock);
            seen = dmem_replay_next | dmem_resp_valid;
        end
        if (r.kill) begin
            if (seen) begin
                $display("killed request to %h was still answered", r.addr);
                other_fails++;
            end
        end else if (!seen) begin
            $display("timeout waiting for replay_next on request to %h", r.addr);
            other_fails++;
        end else begin
            check("dmem_replay_next", 32'(dmem_replay_next), 32'd1);
            check("dmem_resp_valid", 32'(dmem_resp_valid), 32'd0);  // replay comes first
            @(negedge clock);
            check("dmem_resp_valid", 32'(dmem_resp_valid), 32'd1);
            check("dmem_resp_replay", 32'(dmem_resp_replay), 32'd1);
            check("dmem_resp_tag", 32'(dmem_resp_tag), 32'(r.tag));
            check("dmem_resp_addr", dmem_resp_addr, r.addr);
            check("dmem_resp_cmd", 32'(dmem_resp_cmd), 32'(r.cmd));
            check("dmem_resp_typ", 32'(dmem_resp_typ), 32'(r.typ));
            if (r.cmd == c_st) begin
                check("dmem_resp_has_data", 32'(dmem_resp_has_data), 32'd0);
                check("dmem_resp_data", dmem_resp_data, 32'd0);  // no data on a store
                last_store = store_expect(r.addr, r.typ, r.sdata);
                gm_write(r.addr >> 2, last_store ^ r.gm_flip);
            end else begin
                check("dmem_resp_has_data", 32'(dmem_resp_has_data), 32'd1);
                check("dmem_resp_data", dmem_resp_data, load_expect(r.addr, r.typ));
            end
        end
    endtask

    task automatic run_pair(input row_t r);
        int         t;
        int         responses;
        logic [6:0] tag_seen;
        @(posedge clock);
        dmem_req_valid <= 1'b1;
        dmem_req_addr  <= r.addr;
        dmem_req_tag   <= r.tag;
        dmem_req_cmd   <= r.cmd;
        dmem_req_typ   <= r.typ;
        @(posedge clock);  // first accepted
        dmem_req_addr <= r.addr + 32'd4;
        dmem_req_tag  <= r.tag + 7'd1;
        @(posedge clock);  // second accepted
        dmem_req_valid <= 1'b0;
        @(negedge clock);
        check("dmem_s2_nack", 32'(dmem_s2_nack), 32'd0);  // first in stage 2
        check("dmem_ordered", 32'(dmem_ordered), 32'd0);  // stage 2 and pending fill together
        @(negedge clock);
        check("dmem_s2_nack", 32'(dmem_s2_nack), 32'd1);  // second finds the slot taken
        check("dmem_ordered", 32'(dmem_ordered), 32'd1);  // only pending stays
        responses = 0;
        tag_seen  = '0;
        for (t = 0; t < timeout; t++) begin
            @(negedge clock);
            if (dmem_resp_valid) begin
                responses++;
                tag_seen = dmem_resp_tag;
            end
        end
        check("response_count", 32'(responses), 32'd1);
        check("dmem_resp_tag", 32'(tag_seen), 32'(r.tag));
    endtask

    initial begin
        // kind, addr, typ, cmd, tag, store data, kill, golden xor, mismatch
        ops[0]  = '{k_req, 32'h013, sz_w, c_ld, 7'd1, 32'h0, 1'b0, 32'h0, 1'b0};  // unaligned
        ops[1]  = '{k_req, 32'h1fe, sz_w, c_ld, 7'd2, 32'h0, 1'b0, 32'h0, 1'b0};  // wraps
        ops[2]  = '{k_req, 32'h021, sz_b, c_ld, 7'd3, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[3]  = '{k_req, 32'h023, sz_b, c_ld, 7'd4, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[4]  = '{k_req, 32'h032, sz_h, c_ld, 7'd5, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[5]  = '{k_req, 32'h033, sz_h, c_ld, 7'd6, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[6]  = '{k_req, 32'h042, sz_bu, c_ld, 7'd7, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[7]  = '{k_req, 32'h051, sz_hu, c_ld, 7'd8, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[8]  = '{k_req, 32'h060, sz_w, c_ld, 7'd9, 32'h0, 1'b1, 32'h0, 1'b0};  // killed
        ops[9]  = '{k_pair, 32'h070, sz_w, c_ld, 7'd20, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[10] = '{k_req, 32'h081, sz_b, c_st, 7'd30, 32'h7777_77a5, 1'b0, 32'h0, 1'b0};
        ops[11] = '{k_req, 32'h092, sz_h, c_st, 7'd31, 32'h5555_beef, 1'b0, 32'h0, 1'b0};
        ops[12] = '{k_req, 32'h0a0, sz_w, c_st, 7'd32, 32'h1234_5678, 1'b0, 32'h0, 1'b0};
        ops[13] = '{k_gmw, 32'h0a8, sz_w, c_ld, 7'd0, 32'h0, 1'b0, 32'h0, 1'b1};  // wrong index
        ops[14] = '{k_gmw, 32'h0a0, sz_w, c_ld, 7'd0, 32'h0, 1'b0, 32'h0, 1'b0};
        ops[15] = '{k_req, 32'h0c2, sz_hu, c_st, 7'd33, 32'h0000_8001, 1'b0, 32'h100, 1'b1};
        ops[16] = '{k_gmr, 32'h07c, sz_w, c_ld, 7'd0, 32'h0, 1'b0, 32'h0, 1'b1};
        ops[17] = '{k_gmr, 32'h0fc, sz_w, c_ld, 7'd0, 32'h0, 1'b0, 32'h0, 1'b1};

        repeat (8) @(posedge clock);
        reset          <= 1'b0;
        dmem_req_ready <= 1'b1;
        resp_grant     <= 1'b1;  // replay always allowed
        seed = 32'd34;
        for (int i = 0; i < 256; i++) begin
            seed = lcg_next(seed);
            model[i[7:0]] = seed[23:16];  // middle bits, low ones repeat fast
            @(posedge clock);
            preload_en   <= 1'b1;
            preload_addr <= i;
            preload_byte <= seed[23:16];
        end
        @(posedge clock);
        preload_en <= 1'b0;
        @(negedge clock);
        check("dmem_resp_valid", 32'(dmem_resp_valid), 32'd0);
        check("dmem_replay_next", 32'(dmem_replay_next), 32'd0);
        check("dmem_s2_nack", 32'(dmem_s2_nack), 32'd0);
        check("mem_mismatch", 32'(mem_mismatch), 32'd0);
        check("imem_resp_pc", imem_resp_pc, 32'd4096);
        check("imem_resp_data", imem_resp_data, word_at(32'd4096));

        // one accepted instruction, then a redirect
        @(posedge clock);
        imem_resp_valid <= 1'b1;
        imem_resp_ready <= 1'b1;
        @(posedge clock);
        imem_resp_valid <= 1'b0;
        imem_resp_ready <= 1'b0;
        @(negedge clock);
        check("imem_resp_pc", imem_resp_pc, 32'd4100);
        check("imem_resp_data", imem_resp_data, word_at(32'd4100));
        @(posedge clock);
        imem_req_valid <= 1'b1;
        imem_req_pc    <= 32'h0000_2038;
        @(posedge clock);
        imem_req_valid <= 1'b0;
        @(negedge clock);
        check("imem_resp_pc", imem_resp_pc, 32'h0000_2038);
        check("imem_resp_data", imem_resp_data, word_at(32'h0000_2038));

        for (int i = 0; i < n_rows; i++) begin
            case (ops[i].kind)
                k_req:  run_req(ops[i]);
                k_pair: run_pair(ops[i]);
                k_gmw:  gm_write(ops[i].addr >> 2, last_store ^ ops[i].gm_flip);
                default: begin
                    @(posedge clock);
                    gm_raddr <= ops[i].addr >> 2;
                    @(negedge clock);
                    check("gm_rdata", gm_rdata, word_at({ops[i].addr[31:2], 2'b00}));
                end
            endcase
            @(negedge clock);
            check("mem_mismatch", 32'(mem_mismatch), 32'(ops[i].exp_mm));
        end

        $display("errors: %0d wrong values, %0d other failures", errors, other_fails);
        if (errors == 0 && other_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/share_mem_pkg.sv
verilog/byte_memory.sv
verilog/imem_fetch_port.sv
verilog/dmem_req_pipeline.sv
verilog/dmem_data_align.sv
verilog/write_compare.sv
verilog/share_mem_top.sv
verif/tb_share_mem.sv

/* run_sim.sh */
#!/bin/bash
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -j 0 \
    --top-module tb_share_mem -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
